/* bench/cave_controls_properties.sv */
// Bound into cave_controls_top; assumes all inputs change only at clk_sys edges
`timescale 1ns/1ps

module cave_controls_properties import cave_pkg::*; #(
  parameter int HOLD_CYCLES = LOCK_HOLD_DEFAULT
) (
  input logic          clk_sys,
  input logic          RESET,
  input logic          pll_locked,
  input logic          pll_rst,
  input key_state_t    keys,
  input logic [31:0]   joy_0,
  input logic [31:0]   joy_1,
  input player_input_t player_1,
  input player_input_t player_2
);

  localparam int IN_W = $bits(key_state_t) + 64;

  logic [IN_W-1:0] in_q;
  logic            inputs_moved;

  // Mapper sources one edge back, and whether they moved then
  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      in_q         <= '0;
      inputs_moved <= 1'b0;
    end else begin
      in_q         <= {keys, joy_0, joy_1};
      inputs_moved <= {keys, joy_0, joy_1} != in_q;
    end
  end

  //////////////////////////////
  // Reset and lock timing
  //////////////////////////////

  assert property (@(posedge clk_sys) RESET |-> !pll_rst && player_1 == '0 && player_2 == '0)
    else $error("Outputs not clear while RESET is high");

  // Drop seen at one edge, request raised at the next
  assert property (@(posedge clk_sys) disable iff (RESET)
    $rose(pll_rst) |-> $past(pll_locked, 3) && !$past(pll_locked, 2))
    else $error("pll_rst rose without a lock loss two edges before");

  assert property (@(posedge clk_sys) disable iff (RESET)
    $fell(pll_rst) |-> $past(pll_rst, HOLD_CYCLES))
    else $error("pll_rst dropped before the hold time ran out");

  //////////////////////////////
  // Player outputs
  //////////////////////////////

  assert property (@(posedge clk_sys) disable iff (RESET)
    (player_1 != $past(player_1) || player_2 != $past(player_2)) |-> inputs_moved)
    else $error("Player output moved without an input change one cycle before");

endmodule

bind cave_controls_top cave_controls_properties #(
  .HOLD_CYCLES(LOCK_HOLD_CYCLES)
) u_properties (
  .clk_sys    (clk_sys),
  .RESET      (RESET),
  .pll_locked (pll_locked),
  .pll_rst    (pll_rst),
  .keys       (keys),
  .joy_0      (joy_0),
  .joy_1      (joy_1),
  .player_1   (player_1),
  .player_2   (player_2)
);

/* bench/tb_cave_controls.sv */
// Directed tests with a fixed seed; UUT runs a 16 cycle lock hold, outputs sampled on the falling edge
`timescale 1ns/1ps

module tb_cave_controls import cave_pkg::*; ();

  localparam int HOLD = 16;
  localparam int LOCK_CYCLES = 32;
  // Reset, 19 key events, gamepad, 64 video steps, two lock runs
  localparam int TEST_CYCLES = 4 + 19 * 3 + 122 + 64 * 2 + 2 * LOCK_CYCLES;
  localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES;

  logic          clk_sys;
  logic          RESET;
  logic          pll_locked;
  ps2_event_t    ps2_event;
  logic [31:0]   joy_0;
  logic [31:0]   joy_1;
  logic [31:0]   status;
  logic          forced_scandoubler;
  logic          pll_rst;
  player_input_t player_1;
  player_input_t player_2;
  video_opts_t   video_opts;

  // Key model, bit i belongs to sc_table[i]
  logic [22:0] held;
  logic [7:0]  sc_table [23] = '{SC_UP, SC_DOWN, SC_LEFT, SC_RIGHT, SC_CTRL, SC_ALT, SC_SHIFT,
                                 SC_SPACE, SC_1, SC_2, SC_5, SC_6, SC_9, SC_0, SC_A, SC_S,
                                 SC_Q, SC_R, SC_F, SC_D, SC_G, SC_P, SC_W};
  logic        toggle_q;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          cycle_count = 0;
  bit          verdict_given = 1'b0;

  cave_controls_top #(
    .LOCK_HOLD_CYCLES(HOLD)
  ) UUT (
    .clk_sys            (clk_sys),
    .RESET              (RESET),
    .pll_locked         (pll_locked),
    .ps2_event          (ps2_event),
    .joy_0              (joy_0),
    .joy_1              (joy_1),
    .status             (status),
    .forced_scandoubler (forced_scandoubler),
    .pll_rst            (pll_rst),
    .player_1           (player_1),
    .player_2           (player_2),
    .video_opts         (video_opts)
  );

  initial begin
    clk_sys = 1'b0;
    forever #50 clk_sys = ~clk_sys;
  end

  always @(posedge clk_sys) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      verdict_given = 1'b1;
      $display("Timeout: no verdict after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // Run cut short by an assertion stop
  final begin
    if (!verdict_given) begin
      $display("Simulation ended before the verdict");
      $display("Test failed");
    end
  end

  //////////////////////////////
  // Expected values
  //////////////////////////////

  // P1 arrows, ctrl alt space shift, 1 5 p 9; P2 rfdg, asqw, 2 6 0
  function automatic player_input_t expect_player(input bit second, input logic [31:0] joy);
    player_input_t e;
    e.up      = joy[JOY_UP] | (second ? held[17] : held[0]);
    e.down    = joy[JOY_DOWN] | (second ? held[18] : held[1]);
    e.left    = joy[JOY_LEFT] | (second ? held[19] : held[2]);
    e.right   = joy[JOY_RIGHT] | (second ? held[20] : held[3]);
    e.buttons = joy[JOY_BTN_LSB +: 4] | (second ? {held[22], held[16], held[15], held[14]}
                                                : {held[6], held[7], held[5], held[4]});
    e.start   = joy[JOY_START] | (second ? held[9] : held[8]);
    e.coin    = joy[JOY_COIN] | (second ? held[11] : held[10]);
    e.pause   = joy[JOY_PAUSE] | (!second && held[21]);
    e.service = joy[JOY_SERVICE] | (second ? held[13] : held[12]);
    return e;
  endfunction

  function automatic video_opts_t expect_video(input logic [31:0] st, input logic fsd);
    video_opts_t e;
    int          fx;
    fx = int'(st[6:4]);
    e = '0;
    if (st[1]) begin
      e.arx = 12'd16;
      e.ary = 12'd9;
    end else if (st[2]) begin
      e.arx = 12'd3;
      e.ary = 12'd4;
    end else begin
      e.arx = 12'd4;
      e.ary = 12'd3;
    end
    e.scanline    = (fx == 0) ? 2'd0 : 2'(fx - 1);
    e.hq2x        = fx == 1;
    e.scandoubler = (fx != 0) || fsd;
    e.rotate      = st[2];
    e.flip        = st[3];
    return e;
  endfunction

  //////////////////////////////
  // Compare and report
  //////////////////////////////

  task automatic check_player(input string name, input player_input_t exp, input player_input_t act);
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_video(input string name, input video_opts_t exp, input video_opts_t act);
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("PASS %s", name);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d mismatches", name, errors - errs_before);
    end
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  // One keyboard event, player records checked two edges on
  task automatic send_key(input string name, input logic [7:0] code, input logic pressed);
    toggle_q = ~toggle_q;
    @(posedge clk_sys);
    ps2_event <= '{toggle: toggle_q, pressed: pressed, extended: 1'b0, code: code};
    for (int i = 0; i < 23; i++)
      if (sc_table[i] == code) held[i] = pressed;
    repeat (2) @(posedge clk_sys);
    @(negedge clk_sys);
    check_player(name, expect_player(1'b0, joy_0), player_1);
    check_player(name, expect_player(1'b1, joy_1), player_2);
  endtask

  task automatic apply_pads(input string name, input logic [31:0] j0, input logic [31:0] j1);
    @(posedge clk_sys);
    joy_0 <= j0;
    joy_1 <= j1;
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_player(name, expect_player(1'b0, j0), player_1);
    check_player(name, expect_player(1'b1, j1), player_2);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic reset_values();
    int start;
    start = errors;
    @(negedge clk_sys);
    check_bit("reset", 1'b0, pll_rst);
    check_player("reset", '0, player_1);
    check_player("reset", '0, player_2);
    check_video("reset", expect_video(32'd0, 1'b0), video_opts);
    end_test("reset", start);
  endtask

  task automatic keyboard_events();
    int start;
    start = errors;
    for (int i = 0; i < 12; i++)
      send_key("keyboard", sc_table[$urandom % 23], 1'b1);
    for (int i = 0; i < 6; i++)
      send_key("keyboard", sc_table[$urandom % 23], 1'b0);
    // Enter is not tracked
    send_key("keyboard", 8'h5A, 1'b1);
    end_test("keyboard", start);
  endtask

  task automatic gamepad_merge();
    int          start;
    logic [31:0] j1;
    start = errors;
    for (int i = 0; i < 23; i++)
      if (held[i]) send_key("gamepad", sc_table[i], 1'b0);
    for (int i = 0; i < 8; i++)
      apply_pads("gamepad", $urandom, $urandom);
    // P key held, player 2 pause must follow its pad alone
    send_key("gamepad", SC_P, 1'b1);
    for (int i = 0; i < 5; i++)
      send_key("gamepad", sc_table[$urandom % 23], 1'b1);
    for (int i = 0; i < 8; i++) begin
      j1 = $urandom;
      j1[JOY_PAUSE] = 1'(i % 2);
      apply_pads("gamepad_or", $urandom, j1);
    end
    end_test("gamepad", start);
  endtask

  task automatic video_walk();
    int          start;
    logic [31:0] st;
    start = errors;
    for (int a = 0; a < 4; a++) begin
      for (int fx = 0; fx < 8; fx++) begin
        for (int f = 0; f < 2; f++) begin
          st = $urandom;
          st[2:1] = 2'(a);
          st[6:4] = 3'(fx);
          @(posedge clk_sys);
          status <= st;
          forced_scandoubler <= 1'(f);
          @(posedge clk_sys);
          @(negedge clk_sys);
          check_video("video", expect_video(st, 1'(f)), video_opts);
        end
      end
    end
    end_test("video", start);
  endtask

  // One cycle lock drop at cycle 0, optional second drop inside the hold
  task automatic lock_loss(input string name, input int second_drop);
    int   start;
    int   last_drop;
    logic exp_rst;
    start = errors;
    last_drop = -1;
    for (int c = 0; c < LOCK_CYCLES; c++) begin
      @(posedge clk_sys);
      pll_locked <= !(c == 0 || c == second_drop);
      @(negedge clk_sys);
      // Drop driven at edge d raises the request at edge d + 2
      if (c == 2 || (second_drop >= 0 && c == second_drop + 2)) last_drop = c - 2;
      exp_rst = (last_drop >= 0) && (c - last_drop <= HOLD + 1);
      check_bit(name, exp_rst, pll_rst);
    end
    end_test(name, start);
  endtask

  initial begin
    void'($urandom(32'hebb51746));
    RESET = 1'b1;
    pll_locked = 1'b1;
    ps2_event = '0;
    joy_0 = '0;
    joy_1 = '0;
    status = '0;
    forced_scandoubler = 1'b0;
    held = '0;
    toggle_q = 1'b0;
    repeat (2) @(posedge clk_sys);
    RESET <= 1'b0;
    reset_values();
    keyboard_events();
    gamepad_merge();
    video_walk();
    lock_loss("lock_single", -1);
    lock_loss("lock_restart", 8);
    verdict_given = 1'b1;
    $display("Summary: %0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
             errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log holds the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_cave_controls \
  -Mdir obj_dir -o sim_tb
rc=$?
if [ $rc -ne 0 ]; then
  echo "Verilator build failed with status $rc"
  exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
rc=$?
cat "$LOG"
if [ $rc -ne 0 ]; then
  echo "Simulation exited with status $rc"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* source/cave_controls_top.sv */
// All inputs must already be synchronous to clk_sys; keyboard reaches the players two cycles late
`timescale 1ns/1ps

module cave_controls_top import cave_pkg::*; #(
  parameter int LOCK_HOLD_CYCLES = LOCK_HOLD_DEFAULT
) (
  input  logic          clk_sys,
  input  logic          RESET,
  input  logic          pll_locked,
  input  ps2_event_t    ps2_event,
  input  logic [31:0]   joy_0,
  input  logic [31:0]   joy_1,
  input  logic [31:0]   status,
  input  logic          forced_scandoubler,
  output logic          pll_rst,
  output player_input_t player_1,
  output player_input_t player_2,
  output video_opts_t   video_opts
);

  key_state_t keys;

  //////////////////////////////
  // Clock housekeeping
  //////////////////////////////

  pll_lock_watch #(
    .LOCK_HOLD_CYCLES(LOCK_HOLD_CYCLES)
  ) u_lock_watch (
    .clk_sys    (clk_sys),
    .RESET      (RESET),
    .pll_locked (pll_locked),
    .pll_rst    (pll_rst)
  );

  //////////////////////////////
  // Player controls
  //////////////////////////////

  key_tracker u_key_tracker (
    .clk_sys   (clk_sys),
    .RESET     (RESET),
    .ps2_event (ps2_event),
    .keys      (keys)
  );

  // Pads go straight in beside the key states
  input_mapper u_input_mapper (
    .clk_sys  (clk_sys),
    .RESET    (RESET),
    .keys     (keys),
    .joy_0    (joy_0),
    .joy_1    (joy_1),
    .player_1 (player_1),
    .player_2 (player_2)
  );

  // Video settings
  video_option_decode u_video_opts (
    .clk_sys            (clk_sys),
    .RESET              (RESET),
    .status             (status),
    .forced_scandoubler (forced_scandoubler),
    .video_opts         (video_opts)
  );

endmodule

/* source/cave_pkg.sv */
// Scancodes are PS/2 set 2 make codes and ignore the E0 prefix; joystick words follow the host core layout
package cave_pkg;

  //////////////////////////////
  // Records
  //////////////////////////////

  // Mirrors the 11-bit host keyboard word
  typedef struct packed {
    logic       toggle;
    logic       pressed;
    logic       extended;
    logic [7:0] code;
  } ps2_event_t;

  // One flag per key the core listens to
  typedef struct packed {
    logic up;
    logic down;
    logic left;
    logic right;
    logic ctrl;
    logic alt;
    logic shift;
    logic space;
    logic num_1;
    logic num_2;
    logic num_5;
    logic num_6;
    logic num_9;
    logic num_0;
    logic a;
    logic s;
    logic q;
    logic r;
    logic f;
    logic d;
    logic g;
    logic p;
    logic w;
  } key_state_t;

  // Button 4 sits in the top bit of buttons
  typedef struct packed {
    logic       up;
    logic       down;
    logic       left;
    logic       right;
    logic [3:0] buttons;
    logic       start;
    logic       coin;
    logic       pause;
    logic       service;
  } player_input_t;

  typedef struct packed {
    logic [11:0] arx;
    logic [11:0] ary;
    logic [1:0]  scanline;
    logic        scandoubler;
    logic        hq2x;
    logic        rotate;
    logic        flip;
  } video_opts_t;

  //////////////////////////////
  // Scancodes
  //////////////////////////////

  localparam logic [7:0] SC_UP    = 8'h75;
  localparam logic [7:0] SC_DOWN  = 8'h72;
  localparam logic [7:0] SC_LEFT  = 8'h6B;
  localparam logic [7:0] SC_RIGHT = 8'h74;
  localparam logic [7:0] SC_CTRL  = 8'h14;
  localparam logic [7:0] SC_ALT   = 8'h11;
  localparam logic [7:0] SC_SHIFT = 8'h12;
  localparam logic [7:0] SC_SPACE = 8'h29;
  localparam logic [7:0] SC_1     = 8'h16;
  localparam logic [7:0] SC_2     = 8'h1E;
  localparam logic [7:0] SC_5     = 8'h2E;
  localparam logic [7:0] SC_6     = 8'h36;
  localparam logic [7:0] SC_9     = 8'h46;
  localparam logic [7:0] SC_0     = 8'h45;
  localparam logic [7:0] SC_A     = 8'h1C;
  localparam logic [7:0] SC_S     = 8'h1B;
  localparam logic [7:0] SC_Q     = 8'h15;
  localparam logic [7:0] SC_R     = 8'h2D;
  localparam logic [7:0] SC_F     = 8'h2B;
  localparam logic [7:0] SC_D     = 8'h23;
  localparam logic [7:0] SC_G     = 8'h34;
  localparam logic [7:0] SC_P     = 8'h4D;
  localparam logic [7:0] SC_W     = 8'h1D;

  //////////////////////////////
  // Joystick layout, defaults
  //////////////////////////////

  localparam int JOY_RIGHT   = 0;
  localparam int JOY_LEFT    = 1;
  localparam int JOY_DOWN    = 2;
  localparam int JOY_UP      = 3;
  localparam int JOY_BTN_LSB = 4;
  localparam int JOY_START   = 8;
  localparam int JOY_COIN    = 9;
  localparam int JOY_PAUSE   = 10;
  localparam int JOY_SERVICE = 11;

  // Hold time in clk_sys cycles after a lock loss
  localparam int LOCK_HOLD_DEFAULT = 256;

endpackage

/* source/input_mapper.sv */
// Only joystick bits 11:0 are read; player 2 has no pause key and gets pause from its pad alone
`timescale 1ns/1ps

module input_mapper import cave_pkg::*; (
  input  logic          clk_sys,
  input  logic          RESET,
  input  key_state_t    keys,
  input  logic [31:0]   joy_0,
  input  logic [31:0]   joy_1,
  output player_input_t player_1,
  output player_input_t player_2
);

  player_input_t p1_keys;
  player_input_t p2_keys;
  player_input_t p1_next;
  player_input_t p2_next;

  // Gamepad word to player record
  function automatic player_input_t joy_fields(input logic [31:0] joy);
    player_input_t rec;
    rec.up      = joy[JOY_UP];
    rec.down    = joy[JOY_DOWN];
    rec.left    = joy[JOY_LEFT];
    rec.right   = joy[JOY_RIGHT];
    rec.buttons = joy[JOY_BTN_LSB +: 4];
    rec.start   = joy[JOY_START];
    rec.coin    = joy[JOY_COIN];
    rec.pause   = joy[JOY_PAUSE];
    rec.service = joy[JOY_SERVICE];
    return rec;
  endfunction

  //////////////////////////////
  // Keyboard side
  //////////////////////////////

  // Player 1 on arrows and the left modifier cluster
  assign p1_keys = '{up: keys.up, down: keys.down, left: keys.left, right: keys.right,
                     buttons: {keys.shift, keys.space, keys.alt, keys.ctrl},
                     start: keys.num_1, coin: keys.num_5, pause: keys.p,
                     service: keys.num_9};

  // Player 2 on RFDG plus ASQW
  assign p2_keys = '{up: keys.r, down: keys.f, left: keys.d, right: keys.g,
                     buttons: {keys.w, keys.q, keys.s, keys.a},
                     start: keys.num_2, coin: keys.num_6, pause: 1'b0,
                     service: keys.num_0};

  // Either source can hold a control
  assign p1_next = p1_keys | joy_fields(joy_0);
  assign p2_next = p2_keys | joy_fields(joy_1);

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      player_1 <= '0;
      player_2 <= '0;
    end else begin
      player_1 <= p1_next;
      player_2 <= p2_next;
    end
  end

endmodule

/* source/key_tracker.sv */
// Acts on a toggle change only; the extended flag is ignored, so E0-prefixed codes alias plain ones
`timescale 1ns/1ps

module key_tracker import cave_pkg::*; (
  input  logic       clk_sys,
  input  logic       RESET,
  input  ps2_event_t ps2_event,
  output key_state_t keys
);

  logic toggle_prev;
  logic new_event;

  // Host flips the toggle once per key event
  assign new_event = ps2_event.toggle != toggle_prev;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      toggle_prev <= 1'b0;
      keys        <= '0;
    end else begin
      toggle_prev <= ps2_event.toggle;
      if (new_event) begin
        // Pressed flag goes straight into the matching key
        case (ps2_event.code)
          SC_UP:    keys.up    <= ps2_event.pressed;
          SC_DOWN:  keys.down  <= ps2_event.pressed;
          SC_LEFT:  keys.left  <= ps2_event.pressed;
          SC_RIGHT: keys.right <= ps2_event.pressed;
          SC_CTRL:  keys.ctrl  <= ps2_event.pressed;
          SC_ALT:   keys.alt   <= ps2_event.pressed;
          SC_SHIFT: keys.shift <= ps2_event.pressed;
          SC_SPACE: keys.space <= ps2_event.pressed;
          SC_1:     keys.num_1 <= ps2_event.pressed;
          SC_2:     keys.num_2 <= ps2_event.pressed;
          SC_5:     keys.num_5 <= ps2_event.pressed;
          SC_6:     keys.num_6 <= ps2_event.pressed;
          SC_9:     keys.num_9 <= ps2_event.pressed;
          SC_0:     keys.num_0 <= ps2_event.pressed;
          SC_A:     keys.a     <= ps2_event.pressed;
          SC_S:     keys.s     <= ps2_event.pressed;
          SC_Q:     keys.q     <= ps2_event.pressed;
          SC_R:     keys.r     <= ps2_event.pressed;
          SC_F:     keys.f     <= ps2_event.pressed;
          SC_D:     keys.d     <= ps2_event.pressed;
          SC_G:     keys.g     <= ps2_event.pressed;
          SC_P:     keys.p     <= ps2_event.pressed;
          SC_W:     keys.w     <= ps2_event.pressed;
          // Untracked codes leave every key alone
          default:  ;
        endcase
      end
    end
  end

endmodule

/* source/pll_lock_watch.sv */
// LOCK_HOLD_CYCLES must be 2 or more; pll_locked is taken as synchronous to clk_sys
`timescale 1ns/1ps

module pll_lock_watch import cave_pkg::*; #(
  parameter int LOCK_HOLD_CYCLES = LOCK_HOLD_DEFAULT
) (
  input  logic clk_sys,
  input  logic RESET,
  input  logic pll_locked,
  output logic pll_rst
);

  localparam int CNT_W = (LOCK_HOLD_CYCLES > 2) ? $clog2(LOCK_HOLD_CYCLES) : 1;

  logic             lock_q;
  logic             lock_prev;
  logic [CNT_W-1:0] hold_cnt;
  logic             lock_lost;

  // High for one cycle after the registered lock drops
  assign lock_lost = lock_prev & ~lock_q;

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      lock_q    <= 1'b0;
      lock_prev <= 1'b0;
      hold_cnt  <= '0;
      pll_rst   <= 1'b0;
    end else begin
      // Two stage history of the lock input
      lock_q    <= pll_locked;
      lock_prev <= lock_q;
      if (lock_lost) begin
        // Fresh loss restarts the hold, even mid count
        hold_cnt <= CNT_W'(LOCK_HOLD_CYCLES - 1);
        pll_rst  <= 1'b1;
      end else if (hold_cnt != '0) begin
        hold_cnt <= hold_cnt - CNT_W'(1);
      end else begin
        pll_rst <= 1'b0;
      end
    end
  end

endmodule

/* source/video_option_decode.sv */
// Status bit 2 both picks 3:4 and rotates; effect codes above 4 wrap the scanline level
`timescale 1ns/1ps

module video_option_decode import cave_pkg::*; (
  input  logic        clk_sys,
  input  logic        RESET,
  input  logic [31:0] status,
  input  logic        forced_scandoubler,
  output video_opts_t video_opts
);

  // Decode of an all-zero status word
  localparam video_opts_t OPTS_IDLE = '{arx: 12'd4, ary: 12'd3, default: '0};

  logic [2:0]  fx;
  logic [2:0]  sl;
  video_opts_t opts_next;

  // Effect field, 0 none, 1 HQ2x, 2 and up CRT levels
  assign fx = status[6:4];
  assign sl = (fx != 3'd0) ? fx - 3'd1 : 3'd0;

  always_comb begin
    opts_next = OPTS_IDLE;
    // Wide wins over vertical
    if (status[1]) begin
      opts_next.arx = 12'd16;
      opts_next.ary = 12'd9;
    end else if (status[2]) begin
      opts_next.arx = 12'd3;
      opts_next.ary = 12'd4;
    end
    opts_next.scanline    = sl[1:0];
    opts_next.hq2x        = fx == 3'd1;
    opts_next.scandoubler = (fx != 3'd0) || forced_scandoubler;
    opts_next.rotate      = status[2];
    opts_next.flip        = status[3];
  end

  always_ff @(posedge clk_sys or posedge RESET) begin
    if (RESET) begin
      video_opts <= OPTS_IDLE;
    end else begin
      video_opts <= opts_next;
    end
  end

endmodule

/* vlog.f */
source/cave_pkg.sv
source/pll_lock_watch.sv
source/key_tracker.sv
source/input_mapper.sv
source/video_option_decode.sv
source/cave_controls_top.sv
bench/cave_controls_properties.sv
bench/tb_cave_controls.sv
